//--- list.f
source/rv_pkg.sv
source/mem_bus_if.sv
source/mem_arbiter.sv
source/unified_ram.sv
source/fetch_stage.sv
source/regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/memwb_stage.sv
source/rv_core_top.sv
tb/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_core -o sim_core

./obj_dir/sim_core

//--- tb/core_vectors.txt
# P byte_addr word : program word loaded by the host
# R rd data : expected retire, in program order ; M byte_addr word : memory after halt
P 00000000 00500093
P 00000004 00700113
P 00000008 002081B3
P 0000000C 40118233
P 00000010 003202B3
P 00000014 10000313
P 00000018 00532023
P 0000001C 00032383
P 00000020 00138433
P 00000024 00840663
P 00000028 FFF00F93
P 0000002C FFF00F93
P 00000030 00C004EF
P 00000034 FFF00F93
P 00000038 FFF00F93
P 0000003C 40848533
P 00000040 00A32223
P 00000044 00000000
P 00000048 FFF00F93
R 01 00000005
R 02 00000007
R 03 0000000C
R 04 00000007
R 05 00000013
R 06 00000100
R 00 00000013
R 07 00000013
R 08 00000018
R 00 00000000
R 09 00000034
R 0A 0000001C
R 00 0000001C
M 00000100 00000013
M 00000104 0000001C

//--- tb/tb_core.sv
`timescale 1ns/1ns

module tb_core;

    localparam int HOST_TIMEOUT = 20;
    localparam int RUN_TIMEOUT = 300;
    localparam int QUIET_CYCLES = 16;

    logic clk;
    logic rst_n;
    logic run;
    logic host_en;
    logic host_we;
    logic [31:0] host_addr;
    logic [31:0] host_wdata;
    logic host_gnt;
    logic [31:0] host_rdata;
    logic retire_valid;
    logic [4:0] retire_rd;
    logic [31:0] retire_data;
    logic halted;

    logic [31:0] prog_addr[$];
    logic [31:0] prog_word[$];
    logic [31:0] ret_rd[$];
    logic [31:0] ret_data[$];
    logic [31:0] mem_addr[$];
    logic [31:0] mem_word[$];

    int fd;
    int n;
    int seed;
    int waited;
    string line;
    string kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rdata;

    rv_core_top uut (
        .clk(clk), .rst_n(rst_n), .run(run),
        .host_en(host_en), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .host_gnt(host_gnt), .host_rdata(host_rdata),
        .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data), .halted(halted)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap) @(negedge clk);
    endtask

    // one host access, rdata is sampled in the cycle after the grant
    task automatic host_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] data);
        int count;
        count = 0;
        @(negedge clk);
        host_en = 1'b1;
        host_we = we;
        host_addr = addr;
        host_wdata = wdata;
        @(negedge clk);
        while (!host_gnt) begin
            count++;
            if (count > HOST_TIMEOUT) begin
                abort_run($sformatf("host access to %h was never granted", addr));
            end
            @(negedge clk);
        end
        data = host_rdata;
        host_en = 1'b0;
        host_we = 1'b0;
    endtask

    task automatic wait_for_retire(input int index);
        int count;
        count = 0;
        @(negedge clk);
        while (!retire_valid) begin
            count++;
            if (count > RUN_TIMEOUT) begin
                abort_run($sformatf("retire %0d never arrived", index));
            end
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        run = 1'b0;
        host_en = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        seed = $urandom(1);

        fd = $fopen("tb/core_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open tb/core_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h", kind, a, b);
            if (n != 3) begin
                abort_run($sformatf("unreadable vector line: %s", line));
            end
            if (kind == "P") begin
                prog_addr.push_back(a);
                prog_word.push_back(b);
            end else if (kind == "R") begin
                ret_rd.push_back(a);
                ret_data.push_back(b);
            end else if (kind == "M") begin
                mem_addr.push_back(a);
                mem_word.push_back(b);
            end else begin
                abort_run($sformatf("unknown vector kind %s", kind));
            end
        end
        $fclose(fd);
        if (prog_addr.size() == 0 || ret_rd.size() == 0 || mem_addr.size() == 0) begin
            abort_run("vector file is missing program, retire or memory lines");
        end

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // load the program, then read it all back
        foreach (prog_addr[i]) begin
            idle_gap();
            host_access(1'b1, prog_addr[i], prog_word[i], rdata);
        end
        foreach (prog_addr[i]) begin
            idle_gap();
            host_access(1'b0, prog_addr[i], '0, rdata);
            check_value($sformatf("readback %h", prog_addr[i]), prog_word[i], rdata);
        end

        @(negedge clk);
        run = 1'b1;
        foreach (ret_rd[i]) begin
            wait_for_retire(i);
            check_value($sformatf("retire %0d rd", i), ret_rd[i], {27'd0, retire_rd});
            check_value($sformatf("retire %0d data", i), ret_data[i], retire_data);
        end

        // nothing else may retire before or after the halt
        waited = 0;
        @(negedge clk);
        while (!halted) begin
            if (retire_valid) begin
                abort_run("an instruction retired beyond the expected sequence");
            end
            waited++;
            if (waited > RUN_TIMEOUT) begin
                abort_run("halted never rose after the last retire");
            end
            @(negedge clk);
        end
        repeat (QUIET_CYCLES) begin
            check_value("retire after halt", 32'd0, {31'd0, retire_valid});
            check_value("halted held", 32'd1, {31'd0, halted});
            @(negedge clk);
        end

        run = 1'b0;
        foreach (mem_addr[i]) begin
            idle_gap();
            host_access(1'b0, mem_addr[i], '0, rdata);
            check_value($sformatf("memory %h", mem_addr[i]), mem_word[i], rdata);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- source/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic host_en,
    input  logic host_we,
    input  logic [31:0] host_addr,
    input  logic [31:0] host_wdata,
    output logic host_gnt,
    output logic [31:0] host_rdata,
    output logic retire_valid,
    output logic [4:0] retire_rd,
    output logic [31:0] retire_data,
    output logic halted
);
    import rv_pkg::*;

    logic inst_valid;
    inst_u inst;
    logic [XLEN-1:0] inst_pc;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic load_stall;
    logic stall_fd;
    logic de_valid;
    logic [OP_W-1:0] de_op;
    logic [REG_W-1:0] de_rd;
    logic [XLEN-1:0] de_a;
    logic [XLEN-1:0] de_b;
    logic [XLEN-1:0] de_imm;
    logic [XLEN-1:0] de_pc;
    logic redirect;
    logic [XLEN-1:0] redirect_pc;
    logic ex_valid;
    logic ex_is_load;
    logic [OP_W-1:0] ex_op;
    logic [REG_W-1:0] ex_rd;
    logic [XLEN-1:0] ex_result;
    logic [XLEN-1:0] ex_store_data;
    logic busy;
    logic wb_valid;
    logic [REG_W-1:0] wb_rd;
    logic [XLEN-1:0] wb_data;

    mem_bus_if host_bus ();
    mem_bus_if data_bus ();
    mem_bus_if fetch_bus ();
    mem_bus_if ram_bus ();

    assign host_bus.req = host_en;
    assign host_bus.we = host_we;
    assign host_bus.addr = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_gnt = host_bus.gnt;
    assign host_rdata = host_bus.rdata;

    assign stall_fd = busy | load_stall;

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .run(run), .halted(halted),
        .stall(stall_fd), .redirect(redirect), .redirect_pc(redirect_pc),
        .bus(fetch_bus), .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .stall(stall_fd), .flush(redirect),
        .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_valid(ex_valid), .ex_is_load(ex_is_load), .ex_rd(ex_rd), .ex_result(ex_result),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .load_stall(load_stall), .de_valid(de_valid), .de_op(de_op), .de_rd(de_rd),
        .de_a(de_a), .de_b(de_b), .de_imm(de_imm), .de_pc(de_pc)
    );

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .wen(wb_valid), .rs1(rs1), .rs2(rs2), .rd(wb_rd),
        .wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .stall(busy),
        .de_valid(de_valid), .de_op(de_op), .de_rd(de_rd), .de_a(de_a), .de_b(de_b),
        .de_imm(de_imm), .de_pc(de_pc), .redirect(redirect), .redirect_pc(redirect_pc),
        .ex_valid(ex_valid), .ex_is_load(ex_is_load), .ex_op(ex_op), .ex_rd(ex_rd),
        .ex_result(ex_result), .ex_store_data(ex_store_data)
    );

    memwb_stage u_memwb (
        .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd),
        .ex_result(ex_result), .ex_store_data(ex_store_data), .bus(data_bus),
        .busy(busy), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .halted(halted)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n), .host(host_bus), .data(data_bus),
        .fetch(fetch_bus), .ram(ram_bus)
    );

    unified_ram u_ram (
        .clk(clk),
        .bus(ram_bus)
    );

    assign retire_valid = wb_valid;
    assign retire_rd = wb_rd;
    assign retire_data = wb_data;
endmodule

//--- source/memwb_stage.sv
`timescale 1ns/1ns

module memwb_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic ex_valid,
    input  logic [rv_pkg::OP_W-1:0] ex_op,
    input  logic [rv_pkg::REG_W-1:0] ex_rd,
    input  logic [rv_pkg::XLEN-1:0] ex_result,
    input  logic [rv_pkg::XLEN-1:0] ex_store_data,
    mem_bus_if.requester bus,
    output logic busy,
    output logic wb_valid,
    output logic [rv_pkg::REG_W-1:0] wb_rd,
    output logic [rv_pkg::XLEN-1:0] wb_data,
    output logic halted
);
    import rv_pkg::*;

    logic live;
    logic is_mem;
    logic done;
    logic ret_q;
    logic load_q;
    logic [REG_W-1:0] rd_q;
    logic [XLEN-1:0] data_q;

    // nothing past the halt word takes effect
    assign live = ex_valid & !halted;
    assign is_mem = (ex_op == OP_LW) | (ex_op == OP_SW);

    assign bus.req = live & is_mem;
    assign bus.we = (ex_op == OP_SW);
    assign bus.addr = ex_result;
    assign bus.wdata = ex_store_data;

    assign busy = bus.req & !bus.gnt;
    assign done = live & (ex_op != OP_NOP) & (ex_op != OP_HALT) & (!is_mem | bus.gnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_q <= 1'b0;
            load_q <= 1'b0;
            halted <= 1'b0;
        end else begin
            ret_q <= done;
            load_q <= done & (ex_op == OP_LW);
            if (live && ex_op == OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_q <= ex_rd;
        data_q <= (ex_op == OP_SW) ? ex_store_data : ex_result;
    end

    assign wb_valid = ret_q;
    assign wb_rd = rd_q;
    // load data arrives the cycle after the grant
    assign wb_data = load_q ? bus.rdata : data_q;

    a_quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> (!wb_valid && !bus.req));
endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,
    input  logic de_valid,
    input  logic [rv_pkg::OP_W-1:0] de_op,
    input  logic [rv_pkg::REG_W-1:0] de_rd,
    input  logic [rv_pkg::XLEN-1:0] de_a,
    input  logic [rv_pkg::XLEN-1:0] de_b,
    input  logic [rv_pkg::XLEN-1:0] de_imm,
    input  logic [rv_pkg::XLEN-1:0] de_pc,
    output logic redirect,
    output logic [rv_pkg::XLEN-1:0] redirect_pc,
    output logic ex_valid,
    output logic ex_is_load,
    output logic [rv_pkg::OP_W-1:0] ex_op,
    output logic [rv_pkg::REG_W-1:0] ex_rd,
    output logic [rv_pkg::XLEN-1:0] ex_result,
    output logic [rv_pkg::XLEN-1:0] ex_store_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] result;
    logic taken;

    always_comb begin
        case (de_op)
            OP_ADD: result = de_a + de_b;
            OP_SUB: result = de_a - de_b;
            OP_LW, OP_SW: result = de_a + de_imm;
            // link value
            OP_JAL: result = de_pc + 32'd4;
            default: result = '0;
        endcase
    end

    assign taken = de_valid & ((de_op == OP_JAL) | ((de_op == OP_BEQ) & (de_a == de_b)));

    // only while the jump actually moves on, so the pulse lasts one cycle
    assign redirect = taken & !stall;
    assign redirect_pc = de_pc + de_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_is_load <= 1'b0;
        end else if (!stall) begin
            ex_valid <= de_valid;
            ex_is_load <= de_valid & (de_op == OP_LW);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_op <= de_op;
            ex_rd <= de_rd;
            ex_result <= result;
            ex_store_data <= de_b;
        end
    end
endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,
    input  logic flush,
    input  logic inst_valid,
    input  rv_pkg::inst_u inst,
    input  logic [rv_pkg::XLEN-1:0] inst_pc,
    output logic [rv_pkg::REG_W-1:0] rs1,
    output logic [rv_pkg::REG_W-1:0] rs2,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    input  logic ex_valid,
    input  logic ex_is_load,
    input  logic [rv_pkg::REG_W-1:0] ex_rd,
    input  logic [rv_pkg::XLEN-1:0] ex_result,
    input  logic wb_valid,
    input  logic [rv_pkg::REG_W-1:0] wb_rd,
    input  logic [rv_pkg::XLEN-1:0] wb_data,
    output logic load_stall,
    output logic de_valid,
    output logic [rv_pkg::OP_W-1:0] de_op,
    output logic [rv_pkg::REG_W-1:0] de_rd,
    output logic [rv_pkg::XLEN-1:0] de_a,
    output logic [rv_pkg::XLEN-1:0] de_b,
    output logic [rv_pkg::XLEN-1:0] de_imm,
    output logic [rv_pkg::XLEN-1:0] de_pc
);
    import rv_pkg::*;

    logic [OP_W-1:0] op;
    logic [REG_W-1:0] src1;
    logic [REG_W-1:0] src2;
    logic [REG_W-1:0] dst;
    logic [XLEN-1:0] imm;
    logic use_imm;
    logic valid_q;
    logic use_imm_q;

    // later stage wins, x0 is never forwarded
    function automatic logic [XLEN-1:0] fwd(input logic [REG_W-1:0] rs,
                                            input logic [XLEN-1:0] file_val);
        logic [XLEN-1:0] val;
        val = file_val;
        if (rs != '0 && wb_valid && wb_rd == rs) begin
            val = wb_data;
        end
        if (rs != '0 && ex_valid && !ex_is_load && ex_rd == rs) begin
            val = ex_result;
        end
        return val;
    endfunction

    always_comb begin
        op = OP_NOP;
        src1 = '0;
        src2 = '0;
        dst = '0;
        imm = '0;
        use_imm = 1'b0;
        case (inst.r.opcode)
            OPC_OP: begin
                op = inst.r.funct7[5] ? OP_SUB : OP_ADD;
                src1 = inst.r.rs1;
                src2 = inst.r.rs2;
                dst = inst.r.rd;
            end
            OPC_OP_IMM: begin
                op = OP_ADD;
                src1 = inst.i.rs1;
                dst = inst.i.rd;
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
                use_imm = 1'b1;
            end
            OPC_LOAD: begin
                op = OP_LW;
                src1 = inst.i.rs1;
                dst = inst.i.rd;
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            end
            OPC_STORE: begin
                op = OP_SW;
                src1 = inst.s.rs1;
                src2 = inst.s.rs2;
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            end
            OPC_BRANCH: begin
                op = OP_BEQ;
                src1 = inst.b.rs1;
                src2 = inst.b.rs2;
                imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            end
            OPC_JAL: begin
                op = OP_JAL;
                dst = inst.j.rd;
                imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                       inst.j.imm11, inst.j.imm10_1, 1'b0};
            end
            default: begin
                // the all-zero word ends the run
                op = (inst == '0) ? OP_HALT : OP_NOP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            de_op <= op;
            de_rd <= dst;
            de_imm <= imm;
            de_pc <= inst_pc;
            rs1 <= src1;
            rs2 <= src2;
            use_imm_q <= use_imm;
        end
    end

    // loaded value is not ready until the load retires
    assign load_stall = valid_q & ex_valid & ex_is_load & (ex_rd != '0) &
                        ((ex_rd == rs1) | (ex_rd == rs2));
    assign de_valid = valid_q & !load_stall;

    assign de_a = fwd(rs1, rs1_data);
    assign de_b = use_imm_q ? de_imm : fwd(rs2, rs2_data);
endmodule

//--- source/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic clk,
    input  logic rst_n,
    input  logic wen,
    input  logic [rv_pkg::REG_W-1:0] rs1,
    input  logic [rv_pkg::REG_W-1:0] rs2,
    input  logic [rv_pkg::REG_W-1:0] rd,
    input  logic [rv_pkg::XLEN-1:0] wdata,
    output logic [rv_pkg::XLEN-1:0] rs1_data,
    output logic [rv_pkg::XLEN-1:0] rs2_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 is never written, so reads of it stay zero
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
endmodule

//--- source/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic halted,
    input  logic stall,
    input  logic redirect,
    input  logic [rv_pkg::XLEN-1:0] redirect_pc,
    mem_bus_if.requester bus,
    output logic inst_valid,
    output rv_pkg::inst_u inst,
    output logic [rv_pkg::XLEN-1:0] inst_pc
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] req_pc_q;
    logic run_q;
    logic pend_q;
    logic hold_valid_q;
    inst_u hold_inst_q;

    assign bus.req = run & run_q & !halted & !stall;
    assign bus.we = 1'b0;
    assign bus.addr = pc_q;
    assign bus.wdata = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= START_ADDR;
            run_q <= 1'b0;
            pend_q <= 1'b0;
            hold_valid_q <= 1'b0;
        end else begin
            run_q <= run;
            // a word granted under a redirect is stale
            pend_q <= bus.gnt & !redirect;
            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (bus.gnt) begin
                pc_q <= pc_q + 32'd4;
            end
            if (redirect) begin
                hold_valid_q <= 1'b0;
            end else if (pend_q && stall) begin
                hold_valid_q <= 1'b1;
            end else if (!stall) begin
                hold_valid_q <= 1'b0;
            end
        end
    end

    // park the returning word while decode is stalled
    always_ff @(posedge clk) begin
        if (bus.gnt) begin
            req_pc_q <= pc_q;
        end
        if (pend_q && stall) begin
            hold_inst_q <= inst_u'(bus.rdata);
        end
    end

    assign inst_valid = pend_q | hold_valid_q;
    assign inst = hold_valid_q ? hold_inst_q : inst_u'(bus.rdata);
    // no grant while stalled, so req_pc_q still matches a parked word
    assign inst_pc = req_pc_q;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00);
endmodule

//--- source/unified_ram.sv
`timescale 1ns/1ns

module unified_ram (
    input logic clk,
    mem_bus_if.responder bus
);
    import rv_pkg::*;

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [MEM_AW-1:0] idx;

    // word index, byte offset dropped
    assign idx = bus.addr[MEM_AW+1:2];

    // every request is served at once
    assign bus.gnt = bus.req;

    always_ff @(posedge clk) begin
        if (bus.req && bus.we) begin
            mem[idx] <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req && !bus.we) begin
            bus.rdata <= mem[idx];
        end
    end
endmodule

//--- source/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input logic clk,
    input logic rst_n,
    mem_bus_if.responder host,
    mem_bus_if.responder data,
    mem_bus_if.responder fetch,
    mem_bus_if.requester ram
);
    // who was granted last cycle, for rdata routing
    logic [2:0] gnt_q;

    // host > data > fetch
    always_comb begin
        host.gnt = host.req & ram.gnt;
        data.gnt = data.req & !host.req & ram.gnt;
        fetch.gnt = fetch.req & !host.req & !data.req & ram.gnt;
    end

    always_comb begin
        ram.req = host.req | data.req | fetch.req;
        if (host.req) begin
            ram.we = host.we;
            ram.addr = host.addr;
            ram.wdata = host.wdata;
        end else if (data.req) begin
            ram.we = data.we;
            ram.addr = data.addr;
            ram.wdata = data.wdata;
        end else begin
            ram.we = fetch.we;
            ram.addr = fetch.addr;
            ram.wdata = fetch.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gnt_q <= '0;
        end else begin
            gnt_q <= {host.gnt, data.gnt, fetch.gnt};
        end
    end

    assign host.rdata = gnt_q[2] ? ram.rdata : '0;
    assign data.rdata = gnt_q[1] ? ram.rdata : '0;
    assign fetch.rdata = gnt_q[0] ? ram.rdata : '0;

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({host.gnt, data.gnt, fetch.gnt}));
endmodule

//--- source/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if;
    import rv_pkg::*;

    logic req;
    logic we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic gnt;
    logic [XLEN-1:0] rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport responder (
        input  req, we, addr, wdata,
        output gnt, rdata
    );
endinterface

//--- source/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;
    localparam int REG_W = 5;
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW = 8;
    localparam logic [XLEN-1:0] START_ADDR = '0;

    // major opcodes
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    // internal op codes, decode through memwb
    localparam int OP_W = 3;
    localparam logic [OP_W-1:0] OP_NOP = 3'd0;
    localparam logic [OP_W-1:0] OP_ADD = 3'd1;
    localparam logic [OP_W-1:0] OP_SUB = 3'd2;
    localparam logic [OP_W-1:0] OP_LW = 3'd3;
    localparam logic [OP_W-1:0] OP_SW = 3'd4;
    localparam logic [OP_W-1:0] OP_BEQ = 3'd5;
    localparam logic [OP_W-1:0] OP_JAL = 3'd6;
    localparam logic [OP_W-1:0] OP_HALT = 3'd7;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [REG_W-1:0] rs2;
            logic [REG_W-1:0] rs1;
            logic [2:0] funct3;
            logic [REG_W-1:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [REG_W-1:0] rs1;
            logic [2:0] funct3;
            logic [REG_W-1:0] rd;
            logic [6:0] opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [REG_W-1:0] rs2;
            logic [REG_W-1:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic imm12;
            logic [5:0] imm10_5;
            logic [REG_W-1:0] rs2;
            logic [REG_W-1:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic imm20;
            logic [9:0] imm10_1;
            logic imm11;
            logic [7:0] imm19_12;
            logic [REG_W-1:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_u;

endpackage
